//--- source/pkt_sched_cfg.svh
`ifndef PKT_SCHED_CFG_SVH
`define PKT_SCHED_CFG_SVH

// payload bits carried by one packet
`define PKT_DATA_W 2

// four buffers of six packets each
`define PKT_NUM_BUFS 4
`define PKT_QUEUE_DEPTH 6

// buffer number and occupancy widths follow from the sizes above
`define PKT_BUF_IDX_W $clog2(`PKT_NUM_BUFS)
`define PKT_OCC_W $clog2(`PKT_QUEUE_DEPTH + 1)

// running totals
`define PKT_CNT_W 16

`endif

//--- source/pkt_sched_pkg.sv
`default_nettype none

`include "pkt_sched_cfg.svh"

package pkt_sched_pkg;

	// one packet's data
	typedef logic [`PKT_DATA_W-1:0] pkt_data_t;

	// buffer number
	typedef logic [`PKT_BUF_IDX_W-1:0] buf_idx_t;

	// queue fill level, 0 up to the full depth
	typedef logic [`PKT_OCC_W-1:0] occ_t;

	// sent and dropped totals
	typedef logic [`PKT_CNT_W-1:0] cnt_t;

	// tie-break direction of the scheduler
	typedef enum logic [0:0] {
		MODE_LATENCY     = 1'b0,
		MODE_RELIABILITY = 1'b1
	} sched_mode_t;

endpackage

`default_nettype wire

//--- source/pkt_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_sched_cfg.svh"

module pkt_queue #(
	parameter int DEPTH = `PKT_QUEUE_DEPTH
) (
	input  wire                            clk,
	input  wire                            rst_n_i,
	input  wire                            push_i,
	input  wire pkt_sched_pkg::pkt_data_t  push_data_i,
	input  wire                            pop_i,
	output pkt_sched_pkg::pkt_data_t       head_o,
	output pkt_sched_pkg::occ_t            occ_o
);

	pkt_sched_pkg::pkt_data_t mem [DEPTH];
	pkt_sched_pkg::occ_t      occ_q;
	pkt_sched_pkg::occ_t      wr_slot;

	// a pop in the same cycle frees one slot ahead of the tail
	assign wr_slot = pop_i ? occ_q - 1'b1 : occ_q;

	// slot 0 is the head and entries move forward on a pop
	always_ff @(posedge clk) begin
		if (pop_i) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				mem[i] <= mem[i + 1];
			end
		end
		// later assignment wins over the shifted value in that slot
		if (push_i) begin
			mem[wr_slot] <= push_data_i;
		end
	end

	// fill level
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			occ_q <= '0;
		end else begin
			case ({push_i, pop_i})
				2'b10:   occ_q <= occ_q + 1'b1;
				2'b01:   occ_q <= occ_q - 1'b1;
				default: occ_q <= occ_q;
			endcase
		end
	end

	assign head_o = mem[0];
	assign occ_o  = occ_q;

endmodule

`default_nettype wire

//--- source/pkt_buffers.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_sched_cfg.svh"

module pkt_buffers (
	input  wire                             clk,
	input  wire                             rst_n_i,
	input  wire [`PKT_NUM_BUFS-1:0]         wr_en_i,
	input  wire pkt_sched_pkg::pkt_data_t   wr_data_i,
	input  wire [`PKT_NUM_BUFS-1:0]         pop_i,
	output pkt_sched_pkg::pkt_data_t        head_o [`PKT_NUM_BUFS],
	output pkt_sched_pkg::occ_t             occ_o [`PKT_NUM_BUFS],
	output logic [`PKT_NUM_BUFS-1:0]        full_o
);

	// one queue per buffer on a shared write data bus
	for (genvar g = 0; g < `PKT_NUM_BUFS; g++) begin : g_queue
		pkt_sched_pkg::pkt_data_t q_head;
		pkt_sched_pkg::occ_t      q_occ;

		pkt_queue #(
			.DEPTH(`PKT_QUEUE_DEPTH)
		) pkt_queue_inst (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.push_i      (wr_en_i[g]),
			.push_data_i (wr_data_i),
			.pop_i       (pop_i[g]),
			.head_o      (q_head),
			.occ_o       (q_occ)
		);

		assign head_o[g] = q_head;
		assign occ_o[g]  = q_occ;

		// full when every slot holds a packet
		assign full_o[g] = (q_occ == pkt_sched_pkg::occ_t'(`PKT_QUEUE_DEPTH));
	end

endmodule

`default_nettype wire

//--- source/pkt_admit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_sched_cfg.svh"

module pkt_admit (
	input  wire                            clk,
	input  wire                            rst_n_i,
	input  wire                            wr_en_i,
	input  wire pkt_sched_pkg::buf_idx_t   wr_buf_i,
	input  wire pkt_sched_pkg::pkt_data_t  wr_data_i,
	input  wire [`PKT_NUM_BUFS-1:0]        full_i,
	output logic [`PKT_NUM_BUFS-1:0]       buf_wr_o,
	output pkt_sched_pkg::pkt_data_t       buf_data_o,
	output logic                           drop_o,
	output pkt_sched_pkg::cnt_t            drop_count_o
);

	logic target_full;
	logic accept;
	logic reject;

	// fullness is judged before the edge so a same-edge pop frees no slot
	assign target_full = full_i[wr_buf_i];
	assign accept      = wr_en_i && !target_full;
	assign reject      = wr_en_i && target_full;

	// one-hot write enable toward the queues
	always_comb begin
		buf_wr_o = '0;
		if (accept) begin
			buf_wr_o[wr_buf_i] = 1'b1;
		end
	end

	assign buf_data_o = wr_data_i;

	// drop pulse lands in the cycle after the rejected write
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			drop_o       <= 1'b0;
			drop_count_o <= '0;
		end else begin
			drop_o <= reject;
			if (reject) begin
				drop_count_o <= drop_count_o + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pkt_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_sched_cfg.svh"

module pkt_scheduler (
	input  wire                              clk,
	input  wire                              rst_n_i,
	input  wire                              rd_en_i,
	input  wire pkt_sched_pkg::sched_mode_t  mode_i,
	input  wire pkt_sched_pkg::occ_t         occ_i [`PKT_NUM_BUFS],
	input  wire pkt_sched_pkg::pkt_data_t    head_i [`PKT_NUM_BUFS],
	output logic [`PKT_NUM_BUFS-1:0]         pop_o,
	output logic                             out_valid_o,
	output pkt_sched_pkg::buf_idx_t          out_buf_o,
	output pkt_sched_pkg::pkt_data_t         out_data_o,
	output pkt_sched_pkg::cnt_t              sent_count_o
);

	pkt_sched_pkg::buf_idx_t best_idx;
	pkt_sched_pkg::occ_t     best_occ;
	logic                    tie_high;
	logic                    fire;

	// reliability mode lets a later buffer win on equal occupancy
	assign tie_high = (mode_i == pkt_sched_pkg::MODE_RELIABILITY);

	// walk the buffers from 0 upward, keep the fullest
	always_comb begin
		best_idx = '0;
		best_occ = occ_i[0];
		for (int i = 1; i < `PKT_NUM_BUFS; i++) begin
			if ((occ_i[i] > best_occ) || (tie_high && (occ_i[i] == best_occ))) begin
				best_idx = pkt_sched_pkg::buf_idx_t'(i);
				best_occ = occ_i[i];
			end
		end
	end

	// the fullest being empty means all are empty
	assign fire = rd_en_i && (best_occ != '0);

	// pop strobe for the chosen buffer
	always_comb begin
		pop_o = '0;
		if (fire) begin
			pop_o[best_idx] = 1'b1;
		end
	end

	// valid and sent count
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid_o  <= 1'b0;
			sent_count_o <= '0;
		end else begin
			out_valid_o <= fire;
			if (fire) begin
				sent_count_o <= sent_count_o + 1'b1;
			end
		end
	end

	// buffer number and data of the sent packet
	always_ff @(posedge clk) begin
		if (fire) begin
			out_buf_o  <= best_idx;
			out_data_o <= head_i[best_idx];
		end
	end

endmodule

`default_nettype wire

//--- source/pkt_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pkt_sched_cfg.svh"

module pkt_sched_top (
	input  wire                              clk,
	input  wire                              rst_n_i,
	input  wire                              wr_en_i,
	input  wire pkt_sched_pkg::buf_idx_t     wr_buf_i,
	input  wire pkt_sched_pkg::pkt_data_t    wr_data_i,
	input  wire                              rd_en_i,
	input  wire pkt_sched_pkg::sched_mode_t  mode_i,
	output logic                             out_valid_o,
	output pkt_sched_pkg::buf_idx_t          out_buf_o,
	output pkt_sched_pkg::pkt_data_t         out_data_o,
	output logic                             drop_o,
	output pkt_sched_pkg::cnt_t              sent_count_o,
	output pkt_sched_pkg::cnt_t              drop_count_o
);

	logic [`PKT_NUM_BUFS-1:0]  buf_wr;
	pkt_sched_pkg::pkt_data_t  buf_data;
	logic [`PKT_NUM_BUFS-1:0]  buf_full;
	logic [`PKT_NUM_BUFS-1:0]  buf_pop;
	pkt_sched_pkg::pkt_data_t  buf_head [`PKT_NUM_BUFS];
	pkt_sched_pkg::occ_t       buf_occ [`PKT_NUM_BUFS];

	// producer side
	pkt_admit pkt_admit_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.wr_en_i      (wr_en_i),
		.wr_buf_i     (wr_buf_i),
		.wr_data_i    (wr_data_i),
		.full_i       (buf_full),
		.buf_wr_o     (buf_wr),
		.buf_data_o   (buf_data),
		.drop_o       (drop_o),
		.drop_count_o (drop_count_o)
	);

	pkt_buffers pkt_buffers_inst (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.wr_en_i   (buf_wr),
		.wr_data_i (buf_data),
		.pop_i     (buf_pop),
		.head_o    (buf_head),
		.occ_o     (buf_occ),
		.full_o    (buf_full)
	);

	// consumer side
	pkt_scheduler pkt_scheduler_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.rd_en_i      (rd_en_i),
		.mode_i       (mode_i),
		.occ_i        (buf_occ),
		.head_i       (buf_head),
		.pop_o        (buf_pop),
		.out_valid_o  (out_valid_o),
		.out_buf_o    (out_buf_o),
		.out_data_o   (out_data_o),
		.sent_count_o (sent_count_o)
	);

endmodule

`default_nettype wire

//--- dv/pkt_sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_sched_tb;

	localparam int CLK_HALF      = 50;
	localparam int RESET_CYCLES  = 3;
	localparam int DRIVE_DELAY   = 1;
	localparam int CHECK_DELAY   = 94;
	localparam int TIMEOUT_SLACK = 20;
	localparam int FIELDS        = 11;
	localparam int MAX_LINES     = 256;
	localparam logic [15:0] END_MARK = 16'hffff;
	localparam string TRACE_FILE = "dv/pkt_sched_trace.txt";

	// trace columns
	localparam int COL_WR_EN    = 0;
	localparam int COL_WR_BUF   = 1;
	localparam int COL_WR_DATA  = 2;
	localparam int COL_RD_EN    = 3;
	localparam int COL_MODE     = 4;
	localparam int COL_VALID    = 5;
	localparam int COL_OUT_BUF  = 6;
	localparam int COL_OUT_DATA = 7;
	localparam int COL_DROP     = 8;
	localparam int COL_SENT_CNT = 9;
	localparam int COL_DROP_CNT = 10;

	logic                       clk;
	logic                       rst_n_i;
	logic                       wr_en_i;
	pkt_sched_pkg::buf_idx_t    wr_buf_i;
	pkt_sched_pkg::pkt_data_t   wr_data_i;
	logic                       rd_en_i;
	pkt_sched_pkg::sched_mode_t mode_i;
	logic                       out_valid_o;
	pkt_sched_pkg::buf_idx_t    out_buf_o;
	pkt_sched_pkg::pkt_data_t   out_data_o;
	logic                       drop_o;
	pkt_sched_pkg::cnt_t        sent_count_o;
	pkt_sched_pkg::cnt_t        drop_count_o;

	logic [15:0] trace_mem [FIELDS * MAX_LINES];
	int          n_lines;
	int unsigned cycle_cnt   = 0;
	int unsigned cycle_limit = 0;
	int          n_checked   = 0;
	int          valid_errs  = 0;
	int          buf_errs    = 0;
	int          data_errs   = 0;
	int          count_errs  = 0;

	pkt_sched_top pkt_sched_top_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.wr_en_i      (wr_en_i),
		.wr_buf_i     (wr_buf_i),
		.wr_data_i    (wr_data_i),
		.rd_en_i      (rd_en_i),
		.mode_i       (mode_i),
		.out_valid_o  (out_valid_o),
		.out_buf_o    (out_buf_o),
		.out_data_o   (out_data_o),
		.drop_o       (drop_o),
		.sent_count_o (sent_count_o),
		.drop_count_o (drop_count_o)
	);

	initial clk = 1'b0;
	always #(CLK_HALF) clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	function automatic logic [15:0] trace_field(input int line, input int col);
		return trace_mem[line * FIELDS + col];
	endfunction

	function automatic int total_errors();
		return valid_errs + buf_errs + data_errs + count_errs;
	endfunction

	task automatic check_valid(input string name, input logic exp, input logic act);
		n_checked++;
		if (act !== exp) begin
			valid_errs++;
			$display("FAILED at %0d ns: %s expected %0b, got %0b", $time, name, exp, act);
		end
	endtask

	task automatic check_buf(input string name, input pkt_sched_pkg::buf_idx_t exp,
			input pkt_sched_pkg::buf_idx_t act);
		n_checked++;
		if (act !== exp) begin
			buf_errs++;
			$display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input pkt_sched_pkg::pkt_data_t exp,
			input pkt_sched_pkg::pkt_data_t act);
		n_checked++;
		if (act !== exp) begin
			data_errs++;
			$display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input pkt_sched_pkg::cnt_t exp,
			input pkt_sched_pkg::cnt_t act);
		n_checked++;
		if (act !== exp) begin
			count_errs++;
			$display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	// n_out is -1 when the trace is unusable
	task automatic load_trace(output int n_out);
		int fd;
		fd = $fopen(TRACE_FILE, "r");
		n_out = -1;
		if (fd == 0) begin
			$display("error: the trace file %s could not be opened", TRACE_FILE);
		end else begin
			$fclose(fd);
			$readmemh(TRACE_FILE, trace_mem);
			for (int i = 0; i < MAX_LINES && n_out < 0; i++) begin
				if (trace_mem[i * FIELDS] == END_MARK) begin
					n_out = i;
				end
			end
			if (n_out < 0) begin
				$display("error: the trace file has no end marker within %0d lines", MAX_LINES);
			end
		end
	endtask

	task automatic drive_idle();
		wr_en_i   = 1'b0;
		wr_buf_i  = '0;
		wr_data_i = '0;
		rd_en_i   = 1'b0;
		mode_i    = pkt_sched_pkg::MODE_LATENCY;
	endtask

	task automatic drive_line(input int line);
		wr_en_i   = trace_field(line, COL_WR_EN) != 0;
		wr_buf_i  = pkt_sched_pkg::buf_idx_t'(trace_field(line, COL_WR_BUF));
		wr_data_i = pkt_sched_pkg::pkt_data_t'(trace_field(line, COL_WR_DATA));
		rd_en_i   = trace_field(line, COL_RD_EN) != 0;
		mode_i    = (trace_field(line, COL_MODE) != 0) ? pkt_sched_pkg::MODE_RELIABILITY
			: pkt_sched_pkg::MODE_LATENCY;
	endtask

	// buffer and data are don't-care while nothing was sent
	task automatic check_line(input int line);
		logic exp_valid;
		exp_valid = trace_field(line, COL_VALID) != 0;
		check_valid("out_valid_o", exp_valid, out_valid_o);
		if (exp_valid) begin
			check_buf("out_buf_o", pkt_sched_pkg::buf_idx_t'(trace_field(line, COL_OUT_BUF)),
				out_buf_o);
			check_data("out_data_o", pkt_sched_pkg::pkt_data_t'(trace_field(line, COL_OUT_DATA)),
				out_data_o);
		end
		check_valid("drop_o", trace_field(line, COL_DROP) != 0, drop_o);
		check_count("sent_count_o", pkt_sched_pkg::cnt_t'(trace_field(line, COL_SENT_CNT)),
			sent_count_o);
		check_count("drop_count_o", pkt_sched_pkg::cnt_t'(trace_field(line, COL_DROP_CNT)),
			drop_count_o);
	endtask

	// line i is sampled one edge after it is driven, checked late in the cycle after that
	task automatic run_trace();
		for (int i = 0; i <= n_lines; i++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			if (i < n_lines) begin
				drive_line(i);
			end else begin
				drive_idle();
			end
			#(CHECK_DELAY);
			if (i > 0) begin
				check_line(i - 1);
			end
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, errors: valid %0d, buf %0d, data %0d, count %0d, total %0d",
			n_checked, valid_errs, buf_errs, data_errs, count_errs, total_errors());
	endtask

	initial begin
		rst_n_i = 1'b0;
		drive_idle();
		load_trace(n_lines);
		if (n_lines < 0) begin
			$display("** FAIL **");
			$finish;
		end else begin
			cycle_limit = n_lines + RESET_CYCLES + TIMEOUT_SLACK;
			repeat (RESET_CYCLES) @(posedge clk);
			#(DRIVE_DELAY);
			rst_n_i = 1'b1;
			run_trace();
			report_counts();
			if (total_errors() == 0) begin
				$display("** PASS **");
			end else begin
				$display("** FAIL **");
			end
			$finish;
		end
	end

	// watchdog
	initial begin
		wait (cycle_limit != 0);
		wait (cycle_cnt >= cycle_limit);
		$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
		report_counts();
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/pkt_sched_trace.txt
// columns: wr_en wr_buf wr_data rd_en mode  out_valid out_buf out_data drop sent_count drop_count
// expected columns hold in the cycle after the edge that samples the line, ffff ends the trace
// idle after reset
0 0 0 0 0  0 0 0 0 0000 0000
0 0 0 0 0  0 0 0 0 0000 0000
// write order kept in buffer 2
1 2 1 0 0  0 0 0 0 0000 0000
1 2 3 0 0  0 0 0 0 0000 0000
1 2 2 0 0  0 0 0 0 0000 0000
0 0 0 1 0  1 2 1 0 0001 0000
0 0 0 1 0  1 2 3 0 0002 0000
0 0 0 1 0  1 2 2 0 0003 0000
// fill buffer 0, seventh write dropped although the same edge pops it
1 0 1 0 0  0 0 0 0 0003 0000
1 0 2 0 0  0 0 0 0 0003 0000
1 0 3 0 0  0 0 0 0 0003 0000
1 0 0 0 0  0 0 0 0 0003 0000
1 0 1 0 0  0 0 0 0 0003 0000
1 0 2 0 0  0 0 0 0 0003 0000
1 0 3 1 0  1 0 1 1 0004 0001
0 0 0 1 0  1 0 2 0 0005 0001
0 0 0 1 0  1 0 3 0 0006 0001
0 0 0 1 0  1 0 0 0 0007 0001
0 0 0 1 0  1 0 1 0 0008 0001
0 0 0 1 0  1 0 2 0 0009 0001
// empty read, then write and read on one edge
0 0 0 1 0  0 0 0 0 0009 0001
1 3 2 1 0  0 0 0 0 0009 0001
0 0 0 1 0  1 3 2 0 000a 0001
// occupancies 2 4 4 1, latency tie goes to buffer 1
1 0 1 0 0  0 0 0 0 000a 0001
1 0 2 0 0  0 0 0 0 000a 0001
1 1 3 0 0  0 0 0 0 000a 0001
1 1 0 0 0  0 0 0 0 000a 0001
1 1 1 0 0  0 0 0 0 000a 0001
1 1 2 0 0  0 0 0 0 000a 0001
1 2 2 0 0  0 0 0 0 000a 0001
1 2 1 0 0  0 0 0 0 000a 0001
1 2 0 0 0  0 0 0 0 000a 0001
1 2 3 0 0  0 0 0 0 000a 0001
1 3 1 0 0  0 0 0 0 000a 0001
0 0 0 1 0  1 1 3 0 000b 0001
// back to 2 4 4 1, reliability tie goes to buffer 2
1 1 0 0 0  0 0 0 0 000b 0001
0 0 0 1 1  1 2 2 0 000c 0001
0 0 0 1 0  1 1 0 0 000d 0001
0 0 0 1 0  1 1 1 0 000e 0001
0 0 0 1 0  1 2 1 0 000f 0001
// all equal, reliability picks 3 and latency picks 0
1 3 2 0 0  0 0 0 0 000f 0001
0 0 0 1 1  1 3 1 0 0010 0001
0 0 0 1 0  1 0 1 0 0011 0001
0 0 0 0 0  0 0 0 0 0011 0001
ffff

//--- pkt_sched.f
+incdir+source
source/pkt_sched_pkg.sv
source/pkt_queue.sv
source/pkt_buffers.sv
source/pkt_admit.sv
source/pkt_scheduler.sv
source/pkt_sched_top.sv
dv/pkt_sched_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= pkt_sched_tb
FILELIST   ?= pkt_sched.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --timing

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail
sim: build
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -qF '** FAIL **' $(LOG); then echo "simulation reported a failure"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
